/* neuronLayerPkg.sv */
`default_nettype none

package neuronLayerPkg;

	localparam int NUM_INPUTS = 15;  // Activations per vector
	localparam int NUM_NEURONS = 4;
	localparam int FIFO_DEPTH = 4;   // Also the credits the loader starts with
	localparam int ACT_WIDTH = 8;

	typedef logic signed [ACT_WIDTH-1:0] activationT;
	typedef logic signed [ACT_WIDTH-1:0] weightT;

	// Element 0 sits in the lowest byte
	typedef logic [NUM_INPUTS*ACT_WIDTH-1:0] inputVectorT;

	// Neuron 0 sits in the lowest byte
	typedef logic [NUM_NEURONS*ACT_WIDTH-1:0] layerOutT;

	typedef logic [$clog2(FIFO_DEPTH+1)-1:0] creditT;
	typedef logic [$clog2(FIFO_DEPTH)-1:0] fifoPtrT;

	// One row per neuron, column i multiplies activation i
	localparam weightT WEIGHTS [NUM_NEURONS][NUM_INPUTS] = '{
		'{
			8'shB7, 8'sh3B, 8'sh4B, 8'sh1D, 8'sh19, 8'shDB, 8'sh0D, 8'sh46,
			8'shF3, 8'sh21, 8'shE1, 8'sh06, 8'sh0E, 8'shAB, 8'shE8
		},
		'{
			8'sh12, 8'shF0, 8'sh05, 8'sh7F, 8'shC4, 8'sh2A, 8'shFE, 8'sh33,
			8'sh09, 8'sh81, 8'sh17, 8'shE6, 8'sh40, 8'sh0B, 8'shD9
		},
		'{
			8'sh01, 8'sh02, 8'shFF, 8'sh10, 8'sh20, 8'shF8, 8'sh0C, 8'shEE,
			8'sh55, 8'sh03, 8'shA0, 8'sh1E, 8'sh07, 8'shF1, 8'sh2C
		},
		'{
			8'shE0, 8'sh6D, 8'sh14, 8'shFA, 8'sh38, 8'sh0F, 8'shC9, 8'sh22,
			8'sh04, 8'sh5A, 8'shF6, 8'sh11, 8'sh9C, 8'sh27, 8'sh08
		}
	};

	localparam weightT BIASES [NUM_NEURONS] = '{8'sh03, 8'shFB, 8'sh0A, 8'sh00};

endpackage

`default_nettype wire

/* activationLoader.sv */
`default_nettype none
`timescale 1ns/1ps

module activationLoader (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  neuronLayerPkg::activationT inData,
	output logic inReady,
	output logic push,
	output neuronLayerPkg::inputVectorT pushVector,
	input  logic creditReturn
);

	typedef enum logic {
		collecting,
		waitCredit
	} loaderStateT;

	loaderStateT state;
	logic [$clog2(neuronLayerPkg::NUM_INPUTS)-1:0] elemCount;
	neuronLayerPkg::inputVectorT vectorReg;
	neuronLayerPkg::creditT credits;
	logic accept;
	logic lastElem;

	assign inReady = (state == collecting);  // Low while a full vector waits
	assign accept = inValid && inReady;
	assign lastElem = (int'(elemCount) == neuronLayerPkg::NUM_INPUTS - 1);
	assign push = (state == waitCredit) && (credits != '0);
	assign pushVector = vectorReg;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= collecting;
			elemCount <= '0;
		end
		else
		begin
			case (state)
				collecting:
				begin
					if (accept)
					begin
						if (lastElem)
						begin
							elemCount <= '0;
							state <= waitCredit;
						end
						else
						begin
							elemCount <= elemCount + 1'b1;
						end
					end
				end
				waitCredit:
				begin
					if (push)
						state <= collecting;
				end
				default:
					state <= collecting;
			endcase
		end
	end

	// Byte lanes fill in arrival order
	always_ff @(posedge clk)
	begin
		if (accept)
			vectorReg[elemCount*neuronLayerPkg::ACT_WIDTH +: neuronLayerPkg::ACT_WIDTH] <= inData;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			credits <= neuronLayerPkg::creditT'(neuronLayerPkg::FIFO_DEPTH);
		end
		else
		begin
			case ({push, creditReturn})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;  // Both or neither cancel out
			endcase
		end
	end

endmodule

`default_nettype wire

/* vectorFifo.sv */
`default_nettype none
`timescale 1ns/1ps

module vectorFifo (
	input  logic clk,
	input  logic reset,
	input  logic push,
	input  neuronLayerPkg::inputVectorT pushVector,
	input  logic pop,
	output logic notEmpty,
	output neuronLayerPkg::inputVectorT headVector,
	output logic creditReturn
);

	neuronLayerPkg::inputVectorT mem [neuronLayerPkg::FIFO_DEPTH];
	neuronLayerPkg::fifoPtrT wrPtr;
	neuronLayerPkg::fifoPtrT rdPtr;
	neuronLayerPkg::creditT count;

	function automatic neuronLayerPkg::fifoPtrT nextPtr(
		input neuronLayerPkg::fifoPtrT ptr
	);
		if (int'(ptr) == neuronLayerPkg::FIFO_DEPTH - 1)
			return '0;
		return ptr + 1'b1;
	endfunction

	assign notEmpty = (count != '0);
	assign headVector = mem[rdPtr];  // Written entry shows up the cycle after push
	assign creditReturn = pop;       // Freed slot goes straight back to the loader

	always_ff @(posedge clk)
	begin
		if (push)
			mem[wrPtr] <= pushVector;
	end

	// Overflow is ruled out by the credit loop, underflow by the consumer
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
				wrPtr <= nextPtr(wrPtr);
			if (pop)
				rdPtr <= nextPtr(rdPtr);
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

/* neuronUnit.sv */
`default_nettype none
`timescale 1ns/1ps

module neuronUnit #(
	parameter int neuronIndex = 0
) (
	input  logic clk,
	input  logic reset,
	input  logic enable,
	input  neuronLayerPkg::inputVectorT activations,
	output neuronLayerPkg::activationT result
);

	neuronLayerPkg::inputVectorT actReg;
	neuronLayerPkg::activationT sumReg;
	neuronLayerPkg::activationT sumNext;

	// Every product keeps its low byte and the running sum wraps at 8 bits
	function automatic neuronLayerPkg::activationT weightedSum(
		input neuronLayerPkg::inputVectorT acts
	);
		neuronLayerPkg::activationT acc;
		neuronLayerPkg::activationT act;
		neuronLayerPkg::activationT prod;
		acc = neuronLayerPkg::BIASES[neuronIndex];
		for (int i = 0; i < neuronLayerPkg::NUM_INPUTS; i++)
		begin
			act = acts[i*neuronLayerPkg::ACT_WIDTH +: neuronLayerPkg::ACT_WIDTH];
			prod = act * neuronLayerPkg::WEIGHTS[neuronIndex][i];
			acc = acc + prod;
		end
		return acc;
	endfunction

	assign sumNext = weightedSum(actReg);

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else if (enable)
		begin
			actReg <= activations;                       // Stage 1
			sumReg <= sumNext;                           // Stage 2
			result <= sumReg[neuronLayerPkg::ACT_WIDTH-1] ? '0 : sumReg;  // ReLU
		end
	end

endmodule

`default_nettype wire

/* neuronLayer.sv */
`default_nettype none
`timescale 1ns/1ps

module neuronLayer (
	input  logic clk,
	input  logic reset,
	input  logic notEmpty,
	input  neuronLayerPkg::inputVectorT headVector,
	output logic pop,
	output logic outValid,
	output neuronLayerPkg::layerOutT outData,
	input  logic outReady
);

	logic stall;
	logic enable;
	neuronLayerPkg::inputVectorT unitInput;
	logic [2:0] validChain;  // One bit per pipeline stage of the units

	assign stall = outValid && !outReady;
	assign enable = !stall;
	assign pop = notEmpty && !stall;

	// Idle slots carry zeros so the units never see stale data
	assign unitInput = pop ? headVector : '0;

	always_ff @(posedge clk)
	begin
		if (reset)
			validChain <= '0;
		else if (enable)
			validChain <= {validChain[1:0], pop};
	end

	assign outValid = validChain[2];

	for (genvar g = 0; g < neuronLayerPkg::NUM_NEURONS; g++)
	begin : gen_neuron
		neuronUnit #(
			.neuronIndex(g)
		) unit_i (
			.clk(clk),
			.reset(reset),
			.enable(enable),
			.activations(unitInput),
			.result(outData[g*neuronLayerPkg::ACT_WIDTH +: neuronLayerPkg::ACT_WIDTH])
		);
	end

endmodule

`default_nettype wire

/* layerTop.sv */
`default_nettype none
`timescale 1ns/1ps

module layerTop (
	input  logic clk,
	input  logic reset,
	input  logic inValid,
	input  neuronLayerPkg::activationT inData,
	output logic inReady,
	output logic outValid,
	output neuronLayerPkg::layerOutT outData,
	input  logic outReady
);

	logic push;
	neuronLayerPkg::inputVectorT pushVector;
	logic creditReturn;
	logic notEmpty;
	neuronLayerPkg::inputVectorT headVector;
	logic pop;

	activationLoader loader_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.push(push),
		.pushVector(pushVector),
		.creditReturn(creditReturn)
	);

	vectorFifo fifo_i (
		.clk(clk),
		.reset(reset),
		.push(push),
		.pushVector(pushVector),
		.pop(pop),
		.notEmpty(notEmpty),
		.headVector(headVector),
		.creditReturn(creditReturn)
	);

	neuronLayer layer_i (
		.clk(clk),
		.reset(reset),
		.notEmpty(notEmpty),
		.headVector(headVector),
		.pop(pop),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

endmodule

`default_nettype wire

/* tbStimulus.svh */
`ifndef TB_STIMULUS_SVH
`define TB_STIMULUS_SVH

localparam int NUM_ROWS = 8;

// Element 0 first in every row
localparam neuronLayerPkg::activationT STIM_ACTS [NUM_ROWS][neuronLayerPkg::NUM_INPUTS] = '{
	'{8'sh07, 8'sh00, 8'sh00, 8'sh00, 8'sh04, 8'sh00, 8'sh00, 8'sh00,
		8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh40, 8'sh00, 8'sh00},  // Wrap, clamp, zero
	'{8'sh00, 8'sh01, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00,
		8'sh00, 8'sh01, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00},
	'{8'sh00, 8'sh00, 8'sh00, 8'shFF, 8'sh00, 8'sh00, 8'sh02, 8'sh00,
		8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00},
	'{8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00,
		8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'shFF, 8'sh01},
	'{8'sh00, 8'sh00, 8'sh80, 8'sh00, 8'sh00, 8'sh01, 8'sh00, 8'sh00,
		8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00},
	'{8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00,
		8'sh02, 8'sh00, 8'sh00, 8'sh03, 8'sh00, 8'sh00, 8'sh00},
	'{8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00,
		8'sh00, 8'sh00, 8'shFF, 8'sh00, 8'sh01, 8'sh00, 8'sh00},
	'{8'sh01, 8'sh00, 8'sh00, 8'sh00, 8'sh01, 8'sh00, 8'sh00, 8'sh01,
		8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00, 8'sh00}
};

// Bit i set puts a random gap in front of element i
localparam logic [14:0] GAP_MASK [NUM_ROWS] = '{
	15'h0000, 15'h0001, 15'h4210, 15'h7FFF, 15'h0A0A, 15'h1000, 15'h0421, 15'h5555
};

localparam bit READY_RANDOM [NUM_ROWS] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1};

// Neuron 3 in the top byte
localparam neuronLayerPkg::layerOutT EXPECTED [NUM_ROWS] = '{
	32'h0051_0000, 32'h000F_6C5F, 32'h0012_7800, 32'h0045_0040,
	32'h0F00_005E, 32'h3B0E_0000, 32'h0071_2430, 32'h3A19_0419
};

`endif

/* tbLayerTop.sv */
`default_nettype none
`timescale 1ns/1ps

module tbLayerTop;

	localparam int CLK_PERIOD = 10;

	`include "tbStimulus.svh"

	localparam int WATCHDOG_CYCLES = 400 * NUM_ROWS;

	logic clk;
	logic reset;
	logic inValid;
	neuronLayerPkg::activationT inData;
	logic inReady;
	logic outValid;
	neuronLayerPkg::layerOutT outData;
	logic outReady;

	int readyMode;  // 0 high, 1 random, 2 held low
	int expRows [$];
	int errorCount;
	int checkCount;
	int resultsSeen;
	int testsRun;
	int testsFailed;
	int testErrorBase;
	time lastAcceptEdge;
	time lastTransferEdge;
	logic holding;
	neuronLayerPkg::layerOutT heldData;

	layerTop dut_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inData(inData),
		.inReady(inReady),
		.outValid(outValid),
		.outData(outData),
		.outReady(outReady)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	function automatic neuronLayerPkg::layerOutT modelLayer(input int row);
		neuronLayerPkg::layerOutT packedOut;
		int acc;
		logic [7:0] low;
		packedOut = '0;
		for (int n = 0; n < neuronLayerPkg::NUM_NEURONS; n++)
		begin
			acc = int'(neuronLayerPkg::BIASES[n]);
			for (int i = 0; i < neuronLayerPkg::NUM_INPUTS; i++)
				acc += int'(STIM_ACTS[row][i]) * int'(neuronLayerPkg::WEIGHTS[n][i]);
			low = acc[7:0];  // One wrap at the end equals a wrap per product
			packedOut[n*8 +: 8] = low[7] ? 8'h00 : low;
		end
		return packedOut;
	endfunction

	task automatic reportMismatch(input string msg);
		errorCount++;
		$display("Error at %0d ns: %s", $time, msg);
	endtask

	task automatic noteFailure(input string msg);
		errorCount++;
		$display("%s (at %0d ns)", msg, $time);
	endtask

	task automatic checkResult(input neuronLayerPkg::layerOutT got);
		int row;
		neuronLayerPkg::layerOutT fromModel;
		resultsSeen++;
		if (expRows.size() == 0)
		begin
			noteFailure("An output arrived with no vector left to match it");
			return;
		end
		row = expRows.pop_front();
		fromModel = modelLayer(row);
		checkCount += 2;
		if (got !== EXPECTED[row])
			reportMismatch($sformatf("row %0d gave %h, table expects %h", row, got, EXPECTED[row]));
		if (got !== fromModel)
			reportMismatch($sformatf("row %0d gave %h, model expects %h", row, got, fromModel));
	endtask

	// Outputs are sampled half a cycle before the edge that transfers them
	always @(negedge clk)
	begin
		if (reset)
			holding = 1'b0;
		else
		begin
			if (holding)
			begin
				checkCount++;
				if (!outValid)
					noteFailure("outValid fell before the waiting result was taken");
				else if (outData !== heldData)
					reportMismatch($sformatf("outData moved from %h to %h while held",
						heldData, outData));
			end
			if (outValid && outReady)
			begin
				lastTransferEdge = $time + CLK_PERIOD / 2;
				checkResult(outData);
			end
			holding = outValid && !outReady;
			heldData = outData;
		end
	end

	always @(posedge clk)
	begin : readyDriver
		int mode;
		mode = readyMode;
		#1;
		case (mode)
			0: outReady = 1'b1;
			1: outReady = ($urandom_range(1, 0) == 1);
			default: outReady = 1'b0;
		endcase
	end

	task automatic applyReset();
		reset = 1'b1;
		inValid = 1'b0;
		expRows.delete();  // Anything in flight is lost
		repeat (10)
			@(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic driveElement(input neuronLayerPkg::activationT value, input int stallLimit,
		output bit accepted);
		int waited;
		waited = 0;
		accepted = 1'b0;
		inValid = 1'b1;
		inData = value;
		@(negedge clk);
		while (!inReady)
		begin
			if (stallLimit > 0 && waited >= stallLimit)
			begin
				@(posedge clk);
				#1;
				inValid = 1'b0;
				return;
			end
			waited++;
			@(negedge clk);
		end
		@(posedge clk);
		lastAcceptEdge = $time;
		#1;
		inValid = 1'b0;
		accepted = 1'b1;
	endtask

	task automatic sendVector(input int row, input bit useGaps, input int stallLimit,
		output bit complete);
		bit accepted;
		complete = 1'b0;
		for (int i = 0; i < neuronLayerPkg::NUM_INPUTS; i++)
		begin
			if (useGaps && GAP_MASK[row][i])
				repeat ($urandom_range(4, 1))
				begin
					@(posedge clk);
					#1;
				end
			driveElement(STIM_ACTS[row][i], stallLimit, accepted);
			if (!accepted)
			begin
				if (i != 0)
					noteFailure("The loader stopped accepting in the middle of a vector");
				return;
			end
		end
		expRows.push_back(row);
		complete = 1'b1;
	endtask

	task automatic waitDrain();
		while (expRows.size() != 0)
			@(negedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic startTest();
		testErrorBase = errorCount;
	endtask

	task automatic finishTest(input string name);
		int newErrors;
		newErrors = errorCount - testErrorBase;
		testsRun++;
		if (newErrors == 0)
			$display("Test %0d %s: passed at %0d ns", testsRun, name, $time);
		else
		begin
			testsFailed++;
			$display("Test %0d %s: failed with %0d errors", testsRun, name, newErrors);
		end
	endtask

	initial
	begin
		bit complete;
		int accepted;
		int seenBefore;
		clk = 1'b0;
		reset = 1'b1;
		inValid = 1'b0;
		inData = '0;
		outReady = 1'b0;
		readyMode = 0;
		holding = 1'b0;
		void'($urandom(36464));
		applyReset();

		startTest();
		sendVector(0, 1'b0, 0, complete);
		waitDrain();
		checkCount++;
		if (lastTransferEdge - lastAcceptEdge != 5 * CLK_PERIOD)
			reportMismatch($sformatf("latency was %0d cycles, expected 5",
				(lastTransferEdge - lastAcceptEdge) / CLK_PERIOD));
		finishTest("single vector");

		startTest();
		seenBefore = resultsSeen;
		for (int r = 0; r < NUM_ROWS; r++)
			sendVector(r, 1'b0, 0, complete);
		waitDrain();
		checkCount++;
		if (resultsSeen - seenBefore != NUM_ROWS)
			noteFailure("Streaming produced the wrong number of results");
		finishTest("streaming");

		startTest();
		readyMode = 1;
		for (int r = 0; r < NUM_ROWS; r++)
			sendVector(r, 1'b0, 0, complete);
		waitDrain();
		readyMode = 0;
		finishTest("output back-pressure");

		startTest();
		readyMode = 2;
		accepted = 0;
		complete = 1'b1;
		while (complete && accepted < 10)
		begin
			sendVector(accepted % NUM_ROWS, 1'b0, 50, complete);
			if (complete)
				accepted++;
		end
		checkCount += 2;
		if (accepted > 8 || accepted < neuronLayerPkg::FIFO_DEPTH + 2)
			reportMismatch($sformatf("%0d vectors accepted with outReady low", accepted));
		if (inReady)
			noteFailure("inReady came back while outReady was held low");
		readyMode = 0;
		waitDrain();
		finishTest("credit limit");

		startTest();
		for (int r = 0; r < NUM_ROWS; r++)
		begin
			readyMode = READY_RANDOM[r] ? 1 : 0;
			sendVector(r, 1'b1, 0, complete);
		end
		waitDrain();
		readyMode = 0;
		finishTest("input gaps");

		startTest();
		readyMode = 2;
		accepted = 0;
		complete = 1'b1;
		while (complete && accepted < 10)
		begin
			sendVector(accepted % NUM_ROWS, 1'b0, 50, complete);
			if (complete)
				accepted++;
		end
		applyReset();  // Buffer full and loader waiting on a credit
		@(negedge clk);
		checkCount += 2;
		if (outValid !== 1'b0)
			noteFailure("outValid was high right after reset");
		if (inReady !== 1'b1)
			noteFailure("inReady was low right after reset");
		@(posedge clk);
		#1;
		for (int i = 0; i < 7; i++)
			driveElement(STIM_ACTS[1][i], 0, complete);
		applyReset();  // Drops a half-filled vector
		readyMode = 0;
		seenBefore = resultsSeen;
		sendVector(2, 1'b0, 0, complete);
		waitDrain();
		repeat (20)
			@(posedge clk);  // Room for a leftover to show up
		#1;
		checkCount++;
		if (resultsSeen - seenBefore != 1)
			noteFailure("Reset left extra or missing results behind");
		finishTest("reset mid-stream");

		$display("Tests run %0d, failed %0d, checks %0d, errors %0d",
			testsRun, testsFailed, checkCount, errorCount);
		if (errorCount == 0 && testsFailed == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* neuronLayer.f */
+incdir+.
neuronLayerPkg.sv
activationLoader.sv
vectorFifo.sv
neuronUnit.sv
neuronLayer.sv
layerTop.sv
tbLayerTop.sv
